//--- Makefile
TOP := tb_rv_core

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- hdl/alu.sv
// RV32I integer ALU
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t   alu_a,
    input  rv_pkg::word_t   alu_b,
    input  rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t   alu_result
);
    import rv_pkg::*;

    logic                   is_sub;
    word_t                  b_eff;
    word_t                  sum;
    logic                   carry;
    logic                   overflow;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [shamt_width-1:0] shamt;

    // compares share the subtractor
    assign is_sub = (alu_op == alu_sub) || (alu_op == alu_slt) || (alu_op == alu_sltu);
    assign b_eff  = alu_b ^ {xlen{is_sub}};

    assign {carry, sum} = {1'b0, alu_a} + {1'b0, b_eff} + {{xlen{1'b0}}, is_sub};

    assign overflow    = (alu_a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != alu_a[xlen-1]);
    assign lt_signed   = sum[xlen-1] ^ overflow;
    assign lt_unsigned = ~carry;  // borrow out of a - b
    assign shamt       = alu_b[shamt_width-1:0];

    always_comb begin
        case (alu_op)
            alu_add, alu_sub: alu_result = sum;
            alu_and:          alu_result = alu_a & alu_b;
            alu_or:           alu_result = alu_a | alu_b;
            alu_xor:          alu_result = alu_a ^ alu_b;
            alu_slt:          alu_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:         alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:          alu_result = alu_a << shamt;
            alu_srl:          alu_result = alu_a >> shamt;
            alu_sra:          alu_result = word_t'($signed(alu_a) >>> shamt);
            default:          alu_result = '0;
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
// Branch and jump resolution
`timescale 1ns/1ps

module branch_unit (
    input  rv_pkg::opcode_t opcode,
    input  logic [2:0]      funct3,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   alu_result,
    output logic            jump_en,
    output rv_pkg::word_t   jump_target
);
    import rv_pkg::*;

    branch_funct_t cond;
    logic          take;

    assign cond = branch_funct_t'(funct3);

    always_comb begin
        case (cond)
            beq:     take = (rs1_data == rs2_data);
            bne:     take = (rs1_data != rs2_data);
            blt:     take = ($signed(rs1_data) < $signed(rs2_data));
            bge:     take = ($signed(rs1_data) >= $signed(rs2_data));
            bltu:    take = (rs1_data < rs2_data);
            bgeu:    take = (rs1_data >= rs2_data);
            default: take = 1'b0;  // funct3 010/011 never taken
        endcase
    end

    always_comb begin
        case (opcode)
            op_branch:       jump_en = take;
            op_jal, op_jalr: jump_en = 1'b1;
            default:         jump_en = 1'b0;
        endcase
    end

    assign jump_target = (opcode == op_jalr) ? {alu_result[xlen-1:1], 1'b0} : alu_result;

endmodule

//--- hdl/commit_unit.sv
// PC and writeback commit
`timescale 1ns/1ps

module commit_unit #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::opcode_t   opcode,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     alu_result,
    input  logic              jump_en,
    input  rv_pkg::word_t     jump_target,
    output rv_pkg::word_t     pc,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    word_t pc_plus4;
    word_t next_pc;
    logic  is_link;    // jal / jalr
    logic  writes_rd;

    assign pc_plus4 = pc + pc_step;
    assign next_pc  = jump_en ? jump_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= next_pc;  // one instruction retired per cycle
        end
    end

    assign is_link = (opcode == op_jal) || (opcode == op_jalr);

    always_comb begin
        case (opcode)
            op_reg, op_imm, op_lui, op_auipc, op_jal, op_jalr: writes_rd = 1'b1;
            default:                                           writes_rd = 1'b0;
        endcase
    end

    // x0 writes are dropped here, so the register file needs no check
    assign wb_en   = writes_rd && (rd != '0) && !reset;
    assign wb_addr = rd;
    assign wb_data = is_link ? pc_plus4 : alu_result;  // return address for links

endmodule

//--- hdl/inst_decoder.sv
// RV32I instruction decoder
`timescale 1ns/1ps

module inst_decoder (
    input  rv_pkg::word_t     inst,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::opcode_t   opcode,
    output logic [2:0]        funct3,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::alu_op_t   alu_op,
    output rv_pkg::word_t     alu_a,
    output rv_pkg::word_t     alu_b
);
    import rv_pkg::*;

    inst_type_t inst_type;
    word_t      imm;
    logic       funct7_5;  // sub / sra select

    assign opcode   = opcode_t'(inst[6:0]);  // unknown codes fall to defaults
    assign funct3   = inst[14:12];
    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign funct7_5 = inst[30];

    always_comb begin
        case (opcode)
            op_reg:             inst_type = type_r;
            op_imm, op_jalr:    inst_type = type_i;
            op_branch:          inst_type = type_b;
            op_lui, op_auipc:   inst_type = type_u;
            op_jal:             inst_type = type_j;
            default:            inst_type = type_n;
        endcase
    end

    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_b:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;  // r-type and unsupported
        endcase
    end

    always_comb begin
        alu_op = alu_add;  // address and upper-immediate math
        if (opcode == op_reg || opcode == op_imm) begin
            case (funct3)
                3'b000:  alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    // operand steering
    always_comb begin
        case (opcode)
            op_lui: begin
                alu_a = '0;
                alu_b = imm;
            end
            op_auipc, op_jal, op_branch: begin
                alu_a = pc;  // pc-relative target
                alu_b = imm;
            end
            op_reg: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            default: begin  // op_imm, op_jalr
                alu_a = rs1_data;
                alu_b = imm;
            end
        endcase
    end

endmodule

//--- hdl/register_file.sv
// Integer register file
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_addr,
    input  rv_pkg::word_t     wb_data,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [num_regs];  // entry 0 is never written

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads as zero
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/rv_core.sv
// Single-cycle RV32I core
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     inst,
    output rv_pkg::word_t     pc,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_addr,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    word_t      alu_a;
    word_t      alu_b;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_result;
    logic       jump_en;
    word_t      jump_target;

    inst_decoder i_inst_decoder (
        .inst     (inst),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .opcode   (opcode),
        .funct3   (funct3),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .alu_op   (alu_op),
        .alu_a    (alu_a),
        .alu_b    (alu_b)
    );

    register_file i_register_file (
        .clk      (clk),
        .wb_en    (wb_en),    // fed back from commit
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu i_alu (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    branch_unit i_branch_unit (
        .opcode      (opcode),
        .funct3      (funct3),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    commit_unit #(
        .reset_pc (reset_pc)
    ) i_commit_unit (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .rd          (rd),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

endmodule

//--- hdl/rv_pkg.sv
// RV32I core definitions
package rv_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;  // x0 included
    localparam int shamt_width    = 5;   // rv32 shift amount

    typedef logic [xlen-1:0]           word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    localparam word_t pc_step = 32'd4;  // sequential fetch stride

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_b,
        type_u,
        type_j,
        type_n  // no immediate
    } inst_type_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct_t;

endpackage

//--- sources.f
hdl/rv_pkg.sv
hdl/inst_decoder.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/commit_unit.sv
hdl/register_file.sv
hdl/rv_core.sv
verification/rv_core_assertions.sv
verification/tb_rv_core.sv

//--- verification/rv_core_assertions.sv
// RV32I core checker
`timescale 1ns/1ps

module rv_core_assertions #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input logic              clk,
    input logic              reset,
    input rv_pkg::word_t     inst,
    input rv_pkg::word_t     pc,
    input logic              wb_en,
    input rv_pkg::reg_addr_t wb_addr,
    input rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    int         fail_count = 0;  // read by the bench
    word_t      shadow [32];     // mirrors committed writes
    logic       started;
    word_t      exp_pc_q;
    logic [6:0] op;
    logic [4:0] rd_f;
    logic [4:0] rs1_f;
    logic [4:0] rs2_f;
    logic [2:0] f3;
    logic       f7_5;
    logic [4:0] sh;
    logic       taken;
    logic       exp_wb_en;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rv1;
    word_t      rv2;
    word_t      opd_b;
    word_t      alu_exp;
    word_t      exp_wb_data;
    word_t      exp_next_pc;

    // reference decode of the current instruction
    always_comb begin
        op    = inst[6:0];
        rd_f  = inst[11:7];
        f3    = inst[14:12];
        rs1_f = inst[19:15];
        rs2_f = inst[24:20];
        f7_5  = inst[30];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        rv1   = (rs1_f == 5'd0) ? 32'd0 : shadow[rs1_f];  // x0 always zero
        rv2   = (rs2_f == 5'd0) ? 32'd0 : shadow[rs2_f];
        opd_b = (op == opc_reg) ? rv2 : imm_i;
        sh    = opd_b[4:0];
        case (f3)
            3'b000:  alu_exp = (op == opc_reg && f7_5) ? rv1 - opd_b : rv1 + opd_b;
            3'b001:  alu_exp = rv1 << sh;
            3'b010:  alu_exp = {31'b0, ($signed(rv1) < $signed(opd_b))};
            3'b011:  alu_exp = {31'b0, (rv1 < opd_b)};
            3'b100:  alu_exp = rv1 ^ opd_b;
            3'b101:  alu_exp = f7_5 ? word_t'($signed(rv1) >>> sh) : rv1 >> sh;
            3'b110:  alu_exp = rv1 | opd_b;
            default: alu_exp = rv1 & opd_b;
        endcase
        case (f3)
            3'b000:  taken = (rv1 == rv2);
            3'b001:  taken = (rv1 != rv2);
            3'b100:  taken = ($signed(rv1) < $signed(rv2));
            3'b101:  taken = ($signed(rv1) >= $signed(rv2));
            3'b110:  taken = (rv1 < rv2);
            3'b111:  taken = (rv1 >= rv2);
            default: taken = 1'b0;
        endcase
        case (op)
            opc_reg, opc_imm, opc_lui, opc_auipc, opc_jal, opc_jalr: begin
                exp_wb_en = (rd_f != 5'd0);
            end
            default: exp_wb_en = 1'b0;  // branches and anything unknown
        endcase
        exp_wb_data = alu_exp;
        exp_next_pc = pc + 32'd4;
        case (op)
            opc_lui:   exp_wb_data = imm_u;
            opc_auipc: exp_wb_data = pc + imm_u;
            opc_jal: begin
                exp_wb_data = pc + 32'd4;
                exp_next_pc = pc + imm_j;
            end
            opc_jalr: begin
                exp_wb_data = pc + 32'd4;
                exp_next_pc = (rv1 + imm_i) & 32'hffff_fffe;
            end
            opc_branch: begin
                if (taken) begin
                    exp_next_pc = pc + imm_b;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started  <= 1'b1;
            exp_pc_q <= exp_next_pc;  // checked against pc one edge later
        end
        if (wb_en) begin
            shadow[wb_addr] <= wb_data;
        end
    end

    reset_quiet: assert property (@(posedge clk) reset |-> !wb_en)
        else begin
            fail_count = fail_count + 1;
            $error("write enable was high during reset");
        end

    first_pc: assert property (@(posedge clk) disable iff (reset) !started |-> pc == reset_pc)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch pc: got %h expected %h", pc, reset_pc);
        end

    next_pc: assert property (@(posedge clk) disable iff (reset) started |-> pc == exp_pc_q)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch pc: got %h expected %h", pc, exp_pc_q);
        end

    wb_en_match: assert property (@(posedge clk) disable iff (reset) wb_en == exp_wb_en)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch wb_en: got %h expected %h", wb_en, exp_wb_en);
        end

    wb_addr_match: assert property (@(posedge clk) disable iff (reset) wb_en |-> wb_addr == rd_f)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch wb_addr: got %h expected %h", wb_addr, rd_f);
        end

    wb_data_match: assert property (@(posedge clk) disable iff (reset)
                                    exp_wb_en |-> wb_data == exp_wb_data)
        else begin
            fail_count = fail_count + 1;
            $error("Mismatch wb_data: got %h expected %h", wb_data, exp_wb_data);
        end

    x0_untouched: assert property (@(posedge clk) wb_en |-> wb_addr != 5'd0)
        else begin
            fail_count = fail_count + 1;
            $error("a register write to x0 was enabled");
        end

endmodule

//--- verification/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t reset_pc     = 32'h0000_0100;
    localparam int    reset_cycles = 10;
    localparam word_t nop          = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t reset_inst   = 32'h0010_0093;  // addi x1, x0, 1

    logic      clk = 1'b0;
    logic      reset;
    word_t     inst;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t  prog [$];
    int     test_end [$];  // first word index past each test
    string  test_name [$];
    integer seed = 32'h1079;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     idx;
    int     cur_test;
    int     base_fail;
    int     total_fail;
    logic   done;

    rv_core #(
        .reset_pc (reset_pc)
    ) i_rv_core (
        .clk     (clk),
        .reset   (reset),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    bind rv_core rv_core_assertions #(
        .reset_pc (reset_pc)
    ) i_rv_core_assertions (
        .clk     (clk),
        .reset   (reset),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the program never reached its end", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic word_t r_format(input logic [6:0] f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] f3,
                                       input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_format(input logic [11:0] imm, input reg_addr_t rs1,
                                       input logic [2:0] f3, input reg_addr_t rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t u_format(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t branch_word(input logic [12:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic reg_addr_t pick_reg();
        int r;
        r = $random(seed);
        return reg_addr_t'(1 + (r & 7));  // x1..x8 carry random data
    endfunction

    function automatic logic [11:0] rand12();
        int r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic [19:0] rand20();
        int r;
        r = $random(seed);
        return r[19:0];
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic close_test(input string name);
        test_end.push_back(prog.size());
        test_name.push_back(name);
    endtask

    task automatic report_test();
        int fails;
        fails = i_rv_core.i_rv_core_assertions.fail_count - base_fail;
        $display("test %0d (%s) done: %0d failures", cur_test, test_name[cur_test], fails);
        base_fail = i_rv_core.i_rv_core_assertions.fail_count;
        cur_test++;
    endtask

    // control flow only moves forward so word index tracks test progress
    task automatic build_program();
        int          k;
        int          j;
        logic [2:0]  f3;
        logic [6:0]  f7;
        reg_addr_t   src1;
        reg_addr_t   src2;
        logic [11:0] imm12;
        word_t       target;
        word_t       upper;
        emit(nop);
        close_test("reset");
        for (k = 1; k <= 8; k++) begin
            emit(u_format(rand20(), reg_addr_t'(k), op_lui));
            emit(i_format(rand12(), reg_addr_t'(k), 3'b000, reg_addr_t'(k), op_imm));
        end
        for (k = 0; k < 8; k++) begin
            imm12 = rand12();
            f3    = 3'(k);
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm12[11:5] = 7'b0;  // legal shift encoding
            end
            emit(i_format(imm12, pick_reg(), f3, reg_addr_t'(9 + k), op_imm));
        end
        imm12 = rand12();
        emit(i_format({7'b0100000, imm12[4:0]}, pick_reg(), 3'b101, 5'd17, op_imm));  // srai
        emit(u_format(rand20(), 5'd18, op_lui));
        emit(u_format(rand20(), 5'd19, op_auipc));
        close_test("immediate ops");
        for (k = 0; k < 16; k++) begin
            f3 = 3'(k);
            f7 = (k >= 8 && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;  // sub, sra
            emit(r_format(f7, pick_reg(), pick_reg(), f3, reg_addr_t'(9 + k)));
        end
        close_test("register ops");
        for (k = 0; k < 12; k++) begin
            j    = k % 6;
            f3   = (j < 2) ? 3'(j) : 3'(j + 2);
            src1 = pick_reg();
            src2 = (k < 6) ? pick_reg() : src1;  // second round on equal operands
            emit(branch_word(13'd8, src2, src1, f3));
            emit(i_format(rand12(), 5'd0, 3'b000, 5'd20, op_imm));
        end
        close_test("branches");
        emit(jal_word(21'd8, 5'd25));
        emit(i_format(rand12(), 5'd0, 3'b000, 5'd20, op_imm));
        emit(jal_word(21'd8, 5'd0));
        emit(i_format(rand12(), 5'd0, 3'b000, 5'd20, op_imm));
        target = reset_pc + word_t'(4 * (prog.size() + 4));  // word after the jalr filler
        upper  = (target + 32'h800) >> 12;
        emit(u_format(upper[19:0], 5'd21, op_lui));
        emit(i_format(target[11:0], 5'd21, 3'b000, 5'd21, op_imm));
        emit(i_format(12'd1, 5'd21, 3'b000, 5'd26, op_jalr));  // odd target loses bit 0
        emit(i_format(rand12(), 5'd0, 3'b000, 5'd20, op_imm));
        close_test("jumps");
        emit(i_format(rand12(), pick_reg(), 3'b000, 5'd0, op_imm));
        emit(r_format(7'b0, pick_reg(), pick_reg(), 3'b000, 5'd0));
        emit(u_format(rand20(), 5'd0, op_lui));
        emit(i_format(12'd0, 5'd1, 3'b010, 5'd5, 7'b0000011));  // lw
        emit({7'b0, 5'd2, 5'd1, 3'b010, 5'd8, 7'b0100011});     // sw
        emit(32'h0000_0073);                                    // ecall
        emit(r_format(7'b0, 5'd0, 5'd0, 3'b000, 5'd27));        // reads x0 back
        emit(i_format(rand12(), 5'd0, 3'b110, 5'd28, op_imm));
        emit(nop);
        emit(nop);
        close_test("x0 and unsupported");
    endtask

    initial begin
        reset     = 1'b1;
        inst      = reset_inst;  // a writing instruction held during reset
        done      = 1'b0;
        cur_test  = 0;
        base_fail = 0;
        build_program();
        cycle_limit = prog.size() + reset_cycles + 50;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            idx = int'((pc - reset_pc) >> 2);
            if (idx >= prog.size()) begin
                inst = nop;  // one more edge checks the final pc step
                @(negedge clk);
                done = 1'b1;
            end
            while (cur_test < test_end.size() && idx >= test_end[cur_test]) begin
                report_test();
            end
            if (!done) begin
                inst = prog[idx];  // fetch for the current pc
                @(negedge clk);
            end
        end
        total_fail = i_rv_core.i_rv_core_assertions.fail_count;
        $display("tests run: %0d, failures: %0d", cur_test, total_fail);
        if (total_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
